// File: fetch_predict_top.f
+incdir+hw
hw/fetch_pkg.sv
hw/resolve_pkg.sv
hw/btb_target_store.sv
hw/branch_confidence.sv
hw/next_pc_select.sv
hw/fetch_predict_top.sv
verif/fetch_clock_gen.sv
verif/fetch_predict_tb.sv

// File: Bender.yml
package:
  name: fetch_predict

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/resolve_pkg.sv
      - hw/btb_target_store.sv
      - hw/branch_confidence.sv
      - hw/next_pc_select.sv
      - hw/fetch_predict_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/fetch_clock_gen.sv
      - verif/fetch_predict_tb.sv

// File: verif/fetch_predict_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_predict_tb
    import fetch_pkg::*;
    import resolve_pkg::*;
();

    ////////////////////////////////////////////////////////////////////////////
    // run length and directed addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam int       clk_period      = 40;
    localparam int       reset_cycles    = 16;
    localparam int       directed_cycles = 80;     // upper bound for the directed part
    localparam int       random_cycles   = 1500;
    localparam logic [31:0] pc_a     = 32'h0000_0100; // index 0x40, tag 0
    localparam logic [31:0] pc_b     = 32'h0000_0800; // index 0, tag 1
    localparam logic [31:0] pc_alias = 32'h0000_0900; // index 0x40, tag 1
    localparam resolve_t no_resolve  = '0;

    logic      clk;
    logic      rst_n;
    logic      pc_enable;
    logic      predict_disable;
    resolve_t  resolve;
    fetch_pc_u fetch_pc;
    logic      predict_taken;

    // reference model state
    logic [`FETCH_TAG_W-1:0] m_tag  [`FETCH_ENTRIES];
    logic [31:0]             m_tgt  [`FETCH_ENTRIES];
    logic                    m_conf [`FETCH_ENTRIES];
    logic [31:0]             m_pc;       // expected fetch_pc
    logic [31:0]             m_last;     // pc under resolution
    logic [31:0]             exp_pc;     // what the checks compare against
    logic                    exp_pred;
    logic [31:0]             lfsr;
    int                      error_count;

    fetch_clock_gen #(.period_ns(clk_period), .reset_cycles(reset_cycles)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_predict_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc_enable       (pc_enable),
        .predict_disable (predict_disable),
        .resolve         (resolve),
        .fetch_pc        (fetch_pc),
        .predict_taken   (predict_taken)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        error_count++;
        $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        $display("Checks failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);         // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic resolve_t make_resolve(input logic br, input logic jal,
                                              input logic tk, input logic mis,
                                              input logic [31:0] tgt);
        resolve_t r;
        r.is_branch  = br;
        r.is_jal     = jal;
        r.taken      = tk;
        r.mispredict = mis;
        r.target     = tgt;
        return r;
    endfunction

    // entry at pc's index holds pc's tag and is confident
    function automatic logic entry_predicts(input logic [31:0] pc);
        return m_conf[pc[10:2]] && (m_tag[pc[10:2]] == pc[14:11]);
    endfunction

    // one rising edge as the dut sees it, then the inputs for the next one
    task automatic model_update();
        logic [31:0] next_pc;
        logic        pred;
        pred = entry_predicts(m_pc) && !predict_disable;
        if (resolve.mispredict && !resolve.taken) begin
            next_pc = m_last + 32'd4;                 // refetch after wrong taken guess
        end else if (resolve.mispredict && resolve.taken) begin
            next_pc = resolve.target;
        end else if (pred) begin
            next_pc = m_tgt[m_pc[10:2]];
        end else begin
            next_pc = m_pc + 32'd4;
        end
        if (resolve.taken && (resolve.is_branch || resolve.is_jal)) begin
            m_tag[m_last[10:2]]  = m_last[14:11];
            m_tgt[m_last[10:2]]  = resolve.target;
            m_conf[m_last[10:2]] = 1'b1;
        end else if (!resolve.taken && resolve.mispredict) begin
            m_conf[m_last[10:2]] = 1'b0;
        end
        if (pc_enable) begin
            m_last = m_pc;
            m_pc   = next_pc;
        end
    endtask

    task automatic step_cycle(input logic en, input logic dis, input resolve_t res);
        @(posedge clk);
        model_update();
        pc_enable       <= en;
        predict_disable <= dis;
        resolve         <= res;
        exp_pc   = m_pc;
        exp_pred = entry_predicts(m_pc) && !dis;   // uses the level driven now
    endtask

    // jump from last_pc to pc, returns with fetch_pc == pc
    task automatic goto_pc(input logic [31:0] pc, input logic dis);
        step_cycle(1'b1, dis, make_resolve(1'b0, 1'b1, 1'b1, 1'b1, pc));
        step_cycle(1'b1, dis, no_resolve);
    endtask

    // taken branch at pc, returns with fetch_pc == tgt
    task automatic train_taken(input logic [31:0] pc, input logic [31:0] tgt);
        goto_pc(pc, 1'b0);
        step_cycle(1'b1, 1'b0, make_resolve(1'b1, 1'b0, 1'b1, 1'b1, tgt));
        step_cycle(1'b1, 1'b0, no_resolve);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks against the model, every cycle out of reset
    ////////////////////////////////////////////////////////////////////////////

    a_fetch_pc: assert property (@(negedge clk) disable iff (!rst_n)
                                 fetch_pc.raw === exp_pc)
        else report_mismatch("fetch_pc", exp_pc, fetch_pc.raw);

    a_predict: assert property (@(negedge clk) disable iff (!rst_n)
                                predict_taken === exp_pred)
        else report_mismatch("predict_taken", {31'd0, exp_pred}, {31'd0, predict_taken});

    // hang guard sized from the cycle budget
    initial begin
        #((reset_cycles + directed_cycles + random_cycles) * clk_period + 2000);
        $display("watchdog expired before the stimulus finished");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] tgt;
        logic [31:0] hold_pc;
        logic        en;
        logic        dis;
        logic        mis;
        logic [2:0]  kind;
        resolve_t    res;
        pc_enable       = 1'b0;
        predict_disable = 1'b0;
        resolve         = no_resolve;
        lfsr            = 32'h8a4d3dea;
        error_count     = 0;
        m_pc            = `FETCH_RESET_PC;
        m_last          = `FETCH_RESET_PC;
        exp_pc          = `FETCH_RESET_PC;
        exp_pred        = 1'b0;
        for (int i = 0; i < `FETCH_ENTRIES; i++) begin
            m_tag[i]  = '0;
            m_tgt[i]  = '0;
            m_conf[i] = 1'b0;
        end
        wait (rst_n === 1'b1);

        repeat (8) step_cycle(1'b1, 1'b0, no_resolve);      // sequential fetch

        // taken branch trains a, the next fetch of a predicts b
        train_taken(pc_a, pc_b);
        @(negedge clk);
        check_value("fetch_pc", pc_b, fetch_pc.raw);       // taken mispredict redirect
        goto_pc(pc_a, 1'b0);
        @(negedge clk);
        check_value("predict_taken", 32'd1, {31'd0, predict_taken});

        // a falls through, not-taken mispredict refetches a + 4
        step_cycle(1'b1, 1'b0, make_resolve(1'b1, 1'b0, 1'b0, 1'b1, 32'd0));
        @(negedge clk);
        check_value("fetch_pc", pc_b, fetch_pc.raw);
        step_cycle(1'b1, 1'b0, no_resolve);
        @(negedge clk);
        check_value("fetch_pc", pc_a + 32'd4, fetch_pc.raw);
        goto_pc(pc_a, 1'b0);
        @(negedge clk);
        check_value("predict_taken", 32'd0, {31'd0, predict_taken});

        // same index, other tag
        train_taken(pc_a, pc_b);
        goto_pc(pc_alias, 1'b0);
        @(negedge clk);
        check_value("predict_taken", 32'd0, {31'd0, predict_taken});

        // prediction off for a confident entry
        train_taken(pc_a, pc_b);
        goto_pc(pc_a, 1'b1);
        @(negedge clk);
        check_value("predict_taken", 32'd0, {31'd0, predict_taken});
        step_cycle(1'b1, 1'b1, no_resolve);
        @(negedge clk);
        check_value("fetch_pc", pc_a + 32'd4, fetch_pc.raw);

        // stall holds the pc
        step_cycle(1'b0, 1'b0, no_resolve);
        hold_pc = m_pc;
        repeat (4) step_cycle(1'b0, 1'b0, no_resolve);
        @(negedge clk);
        check_value("fetch_pc", hold_pc, fetch_pc.raw);

        // mixed random traffic in a small address window
        repeat (random_cycles) begin
            rand_bits(2, r);
            en = (r[1:0] != 2'd0);                         // stall one cycle in four
            rand_bits(3, r);
            dis = (r[2:0] == 3'd0);
            rand_bits(3, r);
            kind = r[2:0];
            rand_bits(1, r);
            mis = r[0];
            rand_bits(6, r);
            tgt = {17'd0, 2'b00, r[1:0], 5'd0, r[5:2], 2'b00};  // 4 tags, 16 indexes
            case (kind)
                3'd4:    res = make_resolve(1'b1, 1'b0, 1'b1, mis, tgt);   // taken branch
                3'd5:    res = make_resolve(1'b1, 1'b0, 1'b0, mis, tgt);   // not taken
                3'd6:    res = make_resolve(1'b0, 1'b1, 1'b1, mis, tgt);   // jump
                3'd7:    res = make_resolve(1'b0, 1'b0, 1'b1, 1'b1, tgt);  // bare redirect
                default: res = no_resolve;
            endcase
            step_cycle(en, dis, res);
        end

        // last random inputs still take effect on this edge
        step_cycle(1'b1, 1'b0, no_resolve);
        @(negedge clk);
        #1;
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fetch_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_clock_gen #(
    parameter int period_ns    = 40,  // full clock period
    parameter int reset_cycles = 16   // rising edges with rst_n low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on an edge, the dut still sees reset at that edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/fetch_predict_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_predict_top
    import fetch_pkg::*;
    import resolve_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      pc_enable,        // stall when low
    input  logic      predict_disable,  // btb bypass
    input  resolve_t  resolve,          // from execute, every cycle

    output fetch_pc_u fetch_pc,
    output logic      predict_taken
);

    ////////////////////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////////////////////

    fetch_pc_u   last_pc;     // pc under resolution
    btb_lookup_t lookup;      // target store read
    logic        confident;   // confidence bit read

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    btb_target_store u_btb (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_pc (fetch_pc),
        .last_pc  (last_pc),
        .resolve  (resolve),
        .lookup   (lookup)
    );

    branch_confidence u_conf (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_pc  (fetch_pc),
        .last_pc   (last_pc),
        .resolve   (resolve),
        .confident (confident)
    );

    // owns both pc registers
    next_pc_select u_npc (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc_enable       (pc_enable),
        .predict_disable (predict_disable),
        .resolve         (resolve),
        .lookup          (lookup),
        .confident       (confident),
        .fetch_pc        (fetch_pc),
        .last_pc         (last_pc),
        .predict_taken   (predict_taken)
    );

endmodule

`default_nettype wire

// File: hw/next_pc_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module next_pc_select
    import fetch_pkg::*;
    import resolve_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        pc_enable,       // low stalls fetch
    input  logic        predict_disable, // forces pc + 4 unless recovering

    input  resolve_t    resolve,
    input  btb_lookup_t lookup,
    input  logic        confident,

    output fetch_pc_u   fetch_pc,        // registered fetch address
    output fetch_pc_u   last_pc,         // fetch_pc of the previous enabled cycle
    output logic        predict_taken
);

    ////////////////////////////////////////////////////////////////////////////
    // prediction
    ////////////////////////////////////////////////////////////////////////////

    logic      mis_not_taken;   // predicted taken, fell through
    logic      mis_taken;       // predicted fall through, was taken
    logic [31:0] fetch_plus4;
    logic [31:0] last_plus4;
    fetch_pc_u next_pc;

    // hit + confident + enabled
    assign predict_taken = lookup.tag_hit & confident & ~predict_disable;

    assign fetch_plus4 = fetch_pc.raw + 32'd4;  // sequential path
    assign last_plus4  = last_pc.raw + 32'd4;   // refetch after wrong taken guess

    assign mis_not_taken = resolve.mispredict & ~resolve.taken;
    assign mis_taken     = resolve.mispredict & resolve.taken;

    ////////////////////////////////////////////////////////////////////////////
    // next pc mux
    ////////////////////////////////////////////////////////////////////////////

    // recovery first, then btb, then sequential
    always_comb begin
        if (mis_not_taken) begin
            next_pc.raw = last_plus4;
        end else if (mis_taken) begin
            next_pc.raw = resolve.target;
        end else if (predict_taken) begin
            next_pc.raw = lookup.target;
        end else begin
            next_pc.raw = fetch_plus4;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pc registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc.raw <= `FETCH_RESET_PC;
            last_pc.raw  <= `FETCH_RESET_PC;
        end else if (pc_enable) begin
            fetch_pc <= next_pc;    // one cycle from inputs
            last_pc  <= fetch_pc;   // tracks what execute resolves next
        end
    end

    // both hold together on a stall so resolve keeps pointing at last_pc

endmodule

`default_nettype wire

// File: hw/branch_confidence.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module branch_confidence
    import fetch_pkg::*;
    import resolve_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  fetch_pc_u fetch_pc,   // address in fetch this cycle
    input  fetch_pc_u last_pc,    // address being resolved
    input  resolve_t  resolve,

    output logic      confident   // entry at fetch index predicts taken
);

    ////////////////////////////////////////////////////////////////////////////
    // confidence vector
    ////////////////////////////////////////////////////////////////////////////

    logic [`FETCH_ENTRIES-1:0] conf_q;      // one bit per btb entry

    logic [`FETCH_INDEX_W-1:0] upd_idx;
    logic                      set_conf;    // taken branch or jump
    logic                      clr_conf;    // not taken but fetch predicted taken

    assign upd_idx  = last_pc.fields.index;  // same index as target store write

    assign set_conf = resolve.taken & (resolve.is_branch | resolve.is_jal);
    assign clr_conf = ~resolve.taken & resolve.mispredict;

    // set wins, a taken resolve never clears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conf_q <= '0;                   // nothing predicts out of reset
        end else if (set_conf) begin
            conf_q[upd_idx] <= 1'b1;
        end else if (clr_conf) begin
            conf_q[upd_idx] <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////////////////////

    // plain mux on the fetch index, no tag involved here
    assign confident = conf_q[fetch_pc.fields.index];

    // a bit set by one pc stays set when another tag takes the slot,
    // the tag compare in the target store filters that case

endmodule

`default_nettype wire

// File: hw/btb_target_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module btb_target_store
    import fetch_pkg::*;
    import resolve_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  fetch_pc_u   fetch_pc,  // address in fetch this cycle
    input  fetch_pc_u   last_pc,   // address being resolved by execute
    input  resolve_t    resolve,

    output btb_lookup_t lookup     // target and tag compare for fetch_pc
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    btb_entry_t mem [`FETCH_ENTRIES];   // tag + target per index

    logic [`FETCH_INDEX_W-1:0] rd_idx;  // fetch side
    logic [`FETCH_INDEX_W-1:0] wr_idx;  // resolve side
    btb_entry_t                rd_entry;
    btb_entry_t                wr_entry;
    logic                      wr_en;

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    assign rd_idx   = fetch_pc.fields.index;
    assign rd_entry = mem[rd_idx];              // async read

    assign lookup.target  = rd_entry.target;
    assign lookup.tag_hit = (rd_entry.tag == fetch_pc.fields.tag);

    // hit alone does not predict, confidence is checked in next_pc_select

    ////////////////////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////////////////////

    // any taken branch or jump refreshes its entry
    // not gated by pc_enable, resolve is valid every cycle
    assign wr_en = rst_n & resolve.taken & (resolve.is_branch | resolve.is_jal);

    assign wr_idx          = last_pc.fields.index;
    assign wr_entry.tag    = last_pc.fields.tag;  // tag of the resolved pc
    assign wr_entry.target = resolve.target;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_entry;    // visible to the read next cycle
        end
    end

    // an aliased pc with a different tag overwrites the entry,
    // the older tag then misses and falls back to pc + 4

endmodule

`default_nettype wire

// File: hw/resolve_pkg.sv
`default_nettype none

package resolve_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // branch unit result
    ////////////////////////////////////////////////////////////////////////////

    // outcome of the instruction fetched in the previous enabled cycle
    // driven by execute every cycle, fields are plain strobes
    typedef struct packed {
        logic        is_branch;  // conditional branch resolved
        logic        is_jal;     // jump resolved
        logic        taken;      // control transfer happened
        logic        mispredict; // fetch went the wrong way
        logic [31:0] target;     // resolved target address
    } resolve_t;

    // note that mispredict alone steers recovery in the pc mux,
    // is_branch and is_jal only qualify btb and confidence updates

endpackage

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // field view of a fetch address, msb first
    typedef struct packed {
        logic [31-`FETCH_TAG_W-`FETCH_INDEX_W-2:0] upper;  // bits 31..15, unused by the btb
        logic [`FETCH_TAG_W-1:0]                  tag;    // bits 14..11
        logic [`FETCH_INDEX_W-1:0]                index;  // bits 10..2
        logic [1:0]                               offset; // byte offset, always 0 here
    } fetch_pc_fields_t;

    // one pc word, seen as an address or as btb fields
    typedef union packed {
        logic [31:0]      raw;    // adders and targets
        fetch_pc_fields_t fields; // array index and tag compare
    } fetch_pc_u;

    // one btb target word
    typedef struct packed {
        logic [`FETCH_TAG_W-1:0] tag;    // tag of the pc that wrote it
        logic [31:0]             target; // where that pc went when taken
    } btb_entry_t;

    // combinational result of the target lookup
    typedef struct packed {
        logic [31:0] target;  // stored target at the fetch index
        logic        tag_hit; // stored tag matches the fetch tag
    } btb_lookup_t;

endpackage

`default_nettype wire

// File: hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// btb geometry
////////////////////////////////////////////////////////////////////////////

// index comes from pc bits 10..2
`define FETCH_INDEX_W 9

// tag comes from pc bits 14..11
`define FETCH_TAG_W 4

// one entry per index value
`define FETCH_ENTRIES 512

////////////////////////////////////////////////////////////////////////////
// fetch pc
////////////////////////////////////////////////////////////////////////////

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0

`endif
